// File: filelist.f
design/memPkg.sv
design/byteRam.sv
design/memCtrl.sv
design/instFetch.sv
design/loadStore.sv
design/memSubsystem.sv
verification/memSubsystemAssert.sv
verification/memSubsystemChecker.sv
verification/memSubsystemTb.sv

// File: verification/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    localparam int clkPeriod  = 40;
    localparam logic [31:0] seed = 32'h687a_996e;
    localparam int progWords  = 128;
    localparam int pairs1     = 10;
    localparam int pairs3     = 8;
    localparam int pairs5     = 10;
    localparam int fetchOps   = 24;
    localparam int numOps     = progWords + 2 * (pairs1 + pairs3 + pairs5) + fetchOps;
    // cycles allowed for one operation with stalls and a fetch ahead of it
    localparam int maxLatency = 100;
    localparam longint watchdogNs = longint'(numOps) * maxLatency * clkPeriod + 20000;

    logic                 clk;
    logic                 rst;
    logic                 ioBufferFull;
    logic                 fetchEn;
    logic                 redirect;
    logic [addrWidth-1:0] redirectPc;
    logic                 lsReq;
    memOp_t               lsOp;
    logic [addrWidth-1:0] lsAddr;
    logic [dataWidth-1:0] lsData;
    logic [dataWidth-1:0] inst;
    logic [addrWidth-1:0] instPc;
    logic                 instValid;
    logic                 lsBusy;
    logic                 lsDone;
    logic [dataWidth-1:0] lsResult;
    owner_t               owner;
    int                   errCount;
    int                   checkCount;
    int                   tbErrors;
    int                   checksMark;
    int                   errsMark;
    logic                 stallEn;
    logic [31:0]          rngState;
    logic [31:0]          stallRng = ~seed;

    memSubsystem i_memSubsystem (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .lsReq        (lsReq),
        .lsOp         (lsOp),
        .lsAddr       (lsAddr),
        .lsData       (lsData),
        .inst         (inst),
        .instPc       (instPc),
        .instValid    (instValid),
        .lsBusy       (lsBusy),
        .lsDone       (lsDone),
        .lsResult     (lsResult),
        .owner        (owner)
    );

    memSubsystemChecker i_memSubsystemChecker (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .lsReq      (lsReq),
        .lsOp       (lsOp),
        .lsAddr     (lsAddr),
        .lsData     (lsData),
        .inst       (inst),
        .instPc     (instPc),
        .instValid  (instValid),
        .lsBusy     (lsBusy),
        .lsDone     (lsDone),
        .lsResult   (lsResult),
        .owner      (owner),
        .errCount   (errCount),
        .checkCount (checkCount)
    );

    bind memCtrl memSubsystemAssert i_memSubsystemAssert (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .ramWe        (ramWe),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .owner        (owner),
        .state        (state)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // about one cycle in four is stalled while enabled
    always @(posedge clk) begin
        stallRng = xorshift(stallRng);
        ioBufferFull <= #1 stallEn && (stallRng[1:0] == 2'b00);
    end

    function automatic int totalErrors();
        return errCount + tbErrors + i_memSubsystem.i_memCtrl.i_memSubsystemAssert.failCount;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic runLs(input memOp_t op, input logic [addrWidth-1:0] addr,
                         input logic [dataWidth-1:0] data);
        int waited;
        lsReq  = 1'b1;
        lsOp   = op;
        lsAddr = addr;
        lsData = data;
        nextCycle();
        lsReq  = 1'b0;
        waited = 0;
        while (!lsDone) begin
            nextCycle();
            waited++;
            if (waited > maxLatency) begin
                abortRun("timeout waiting for lsDone");
            end
        end
    endtask

    // store of the matching width, then the load back from the same address
    task automatic storeLoad(input memOp_t loadOp);
        memOp_t               storeOp;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        rngState = xorshift(rngState);
        addr     = 16'h8000 + 16'(rngState[15:0] % 16'h7ff0);
        rngState = xorshift(rngState);
        data     = rngState;
        case (loadOp)
            opLb, opLbu: storeOp = opSb;
            opLh, opLhu: storeOp = opSh;
            default:     storeOp = opSw;
        endcase
        runLs(storeOp, addr, data);
        runLs(loadOp, addr, '0);
    endtask

    task automatic randomPair();
        rngState = xorshift(rngState);
        storeLoad(memOp_t'(rngState % 32'd5));
    endtask

    task automatic waitInst(input int count);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < count) begin
            nextCycle();
            waited++;
            if (instValid) begin
                seen++;
            end
            if (waited > count * maxLatency) begin
                abortRun("timeout waiting for instValid");
            end
        end
    endtask

    // owner idle three cycles in a row means no fetch is left in flight
    task automatic drain();
        int idleRun;
        int waited;
        idleRun = 0;
        waited  = 0;
        while (idleRun < 3) begin
            nextCycle();
            waited++;
            if (owner == ownNone) begin
                idleRun++;
            end else begin
                idleRun = 0;
            end
            if (waited > maxLatency) begin
                abortRun("timeout waiting for the memory to go idle");
            end
        end
    endtask

    task automatic redirectTo(input logic [addrWidth-1:0] pc);
        redirect   = 1'b1;
        redirectPc = pc;
        nextCycle();
        redirect   = 1'b0;
    endtask

    task automatic reportTest(input string name);
        int checks;
        int errs;
        checks = checkCount - checksMark;
        errs   = totalErrors() - errsMark;
        if (checks == 0) begin
            tbErrors++;
            errs++;
            $display("%s: nothing was checked", name);
        end
        $display("%s: %0d checks, %0d errors", name, checks, errs);
        checksMark = checkCount;
        errsMark   = totalErrors();
    endtask

    initial begin
        #(watchdogNs);
        abortRun("watchdog expired before the tests finished");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        redirect     = 1'b0;
        redirectPc   = '0;
        lsReq        = 1'b0;
        lsOp         = opLb;
        lsAddr       = '0;
        lsData       = '0;
        stallEn      = 1'b0;
        rngState     = seed;
        tbErrors     = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        nextCycle();
        checksMark = checkCount;
        errsMark   = totalErrors();

        for (int i = 0; i < pairs1; i++) begin
            storeLoad(memOp_t'(i % 5));
        end
        reportTest("test 1 store and load widths");

        // program image in the lower half
        for (int i = 0; i < progWords; i++) begin
            rngState = xorshift(rngState);
            runLs(opSw, 16'(i * 4), rngState);
        end
        fetchEn = 1'b1;
        waitInst(16);
        fetchEn = 1'b0;
        drain();
        reportTest("test 2 program fetch");

        fetchEn = 1'b1;
        for (int i = 0; i < pairs3; i++) begin
            randomPair();
        end
        fetchEn = 1'b0;
        drain();
        reportTest("test 3 concurrent traffic");

        fetchEn = 1'b1;
        waitInst(1);
        repeat (2) nextCycle();
        rngState = xorshift(rngState);
        redirectTo(16'({rngState[5:0], 2'b00}));
        waitInst(3);
        fetchEn = 1'b0;
        drain();
        reportTest("test 4 redirect");

        redirectTo(16'h0000);
        stallEn = 1'b1;
        fetchEn = 1'b1;
        for (int i = 0; i < pairs5; i++) begin
            randomPair();
        end
        fetchEn = 1'b0;
        stallEn = 1'b0;
        drain();
        reportTest("test 5 stalls");

        // reset lands while a load holds the memory
        lsReq  = 1'b1;
        lsOp   = opLw;
        lsAddr = 16'h8000;
        nextCycle();
        lsReq = 1'b0;
        nextCycle();
        rst = 1'b1;
        repeat (10) nextCycle();
        rst = 1'b0;
        repeat (2) nextCycle();
        reportTest("test 6 reset state");

        $display("total: %0d checks, %0d errors", checkCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/memSubsystemChecker.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemChecker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         redirect,
    input  logic [memPkg::addrWidth-1:0] redirectPc,
    input  logic                         lsReq,
    input  memPkg::memOp_t               lsOp,
    input  logic [memPkg::addrWidth-1:0] lsAddr,
    input  logic [memPkg::dataWidth-1:0] lsData,
    input  logic [memPkg::dataWidth-1:0] inst,
    input  logic [memPkg::addrWidth-1:0] instPc,
    input  logic                         instValid,
    input  logic                         lsBusy,
    input  logic                         lsDone,
    input  logic [memPkg::dataWidth-1:0] lsResult,
    input  memPkg::owner_t               owner,
    output int                           errCount,
    output int                           checkCount
);
    import memPkg::*;

    logic [7:0]           shadow [ramDepth];
    logic [addrWidth-1:0] expPc;
    memOp_t               pendOp;
    logic [addrWidth-1:0] pendAddr;
    logic                 pendValid;
    logic                 busyExpected;
    logic                 busyPrev;
    logic                 rstPrev;

    initial begin
        errCount     = 0;
        checkCount   = 0;
        expPc        = '0;
        pendValid    = 1'b0;
        busyExpected = 1'b0;
        busyPrev     = 1'b0;
        rstPrev      = 1'b0;
    end

    // expected load value, little endian bytes from the shadow copy
    function automatic logic [dataWidth-1:0] refLoad(input memOp_t op,
                                                     input logic [addrWidth-1:0] addr);
        logic [dataWidth-1:0] raw;
        raw = {shadow[addr + 16'd3], shadow[addr + 16'd2], shadow[addr + 16'd1], shadow[addr]};
        case (op)
            opLb:    return {{24{raw[7]}}, raw[7:0]};
            opLbu:   return {24'd0, raw[7:0]};
            opLh:    return {{16{raw[15]}}, raw[15:0]};
            opLhu:   return {16'd0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic writeShadow(input memOp_t op, input logic [addrWidth-1:0] addr,
                               input logic [dataWidth-1:0] data);
        int n;
        n = (op == opSb) ? 1 : ((op == opSh) ? 2 : 4);
        for (int k = 0; k < n; k++) begin
            shadow[addr + 16'(k)] = data[8*k +: 8];
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errCount++;
        $display("%s at %0t ns", what, $time);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // outputs are settled once reset has been seen on an earlier edge
            if (rstPrev) begin
                checkValue("instValid", 32'd0, 32'(instValid));
                checkValue("lsDone", 32'd0, 32'(lsDone));
                checkValue("lsBusy", 32'd0, 32'(lsBusy));
                checkValue("owner", 32'(ownNone), 32'(owner));
            end
            expPc        = '0;
            pendValid    = 1'b0;
            busyExpected = 1'b0;
            rstPrev      = 1'b1;
        end else begin
            rstPrev = 1'b0;
            if (busyExpected) begin
                checkValue("lsBusy", 32'd1, 32'(lsBusy));
            end
            busyExpected = 1'b0;
            if (busyPrev && !lsBusy && !lsDone) begin
                reportProblem("lsBusy dropped without lsDone");
            end
            if (lsDone) begin
                if (lsBusy) begin
                    reportProblem("lsBusy still high together with lsDone");
                end
                if (!pendValid) begin
                    reportProblem("lsDone pulsed with no request outstanding");
                end else if (!(pendOp inside {opSb, opSh, opSw})) begin
                    checkValue("lsResult", refLoad(pendOp, pendAddr), lsResult);
                end
                pendValid = 1'b0;
            end
            if (lsReq && !lsBusy) begin
                pendValid    = 1'b1;
                pendOp       = lsOp;
                pendAddr     = lsAddr;
                busyExpected = 1'b1;
                if (lsOp inside {opSb, opSh, opSw}) begin
                    writeShadow(lsOp, lsAddr, lsData);
                end
            end
            // instruction stream must step by four from the last pc
            if (instValid) begin
                checkValue("instPc", 32'(expPc), 32'(instPc));
                checkValue("inst", refLoad(opLw, instPc), inst);
                expPc = expPc + 16'd4;
            end
            if (redirect) begin
                expPc = redirectPc;
            end
        end
        busyPrev = lsBusy;
    end

endmodule

`default_nettype wire

// File: verification/memSubsystemAssert.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemAssert (
    input logic               clk,
    input logic               rst,
    input logic               ioBufferFull,
    input logic               ramWe,
    input logic               fetchDone,
    input logic               dataDone,
    input memPkg::owner_t     owner,
    input memPkg::ctrlState_t state
);
    import memPkg::*;

    int failCount = 0;

    noWriteWhileFull: assert property (@(posedge clk) disable iff (rst)
        ioBufferFull |-> !ramWe)
        else begin
            failCount++;
            $error("ramWe high while ioBufferFull is high");
        end

    // done pulses go to the client that holds the RAM
    fetchDoneOwner: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> (owner == ownFetch))
        else begin
            failCount++;
            $error("fetchDone while owner is %s", owner.name());
        end

    dataDoneOwner: assert property (@(posedge clk) disable iff (rst)
        dataDone |-> (owner == ownData))
        else begin
            failCount++;
            $error("dataDone while owner is %s", owner.name());
        end

    ownerStable: assert property (@(posedge clk) disable iff (rst)
        (state != stIdle) |=> $stable(owner))
        else begin
            failCount++;
            $error("owner changed during a transfer");
        end

endmodule

`default_nettype wire

// File: design/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ioBufferFull,
    input  logic                         fetchEn,
    input  logic                         redirect,
    input  logic [memPkg::addrWidth-1:0] redirectPc,
    input  logic                         lsReq,
    input  memPkg::memOp_t               lsOp,
    input  logic [memPkg::addrWidth-1:0] lsAddr,
    input  logic [memPkg::dataWidth-1:0] lsData,
    output logic [memPkg::dataWidth-1:0] inst,
    output logic [memPkg::addrWidth-1:0] instPc,
    output logic                         instValid,
    output logic                         lsBusy,
    output logic                         lsDone,
    output logic [memPkg::dataWidth-1:0] lsResult,
    output memPkg::owner_t               owner
);
    import memPkg::*;

    logic                 fetchReq;
    logic [addrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [dataWidth-1:0] fetchData;
    logic                 dataReq;
    logic                 dataWrite;
    logic [2:0]           dataLen;
    logic [addrWidth-1:0] dataAddr;
    logic [dataWidth-1:0] dataWdata;
    logic                 dataDone;
    logic [dataWidth-1:0] dataRdata;
    logic                 ramWe;
    logic [addrWidth-1:0] ramAddr;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    memCtrl i_memCtrl (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchData    (fetchData),
        .dataReq      (dataReq),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .ramWe        (ramWe),
        .ramAddr      (ramAddr),
        .ramWdata     (ramWdata),
        .ramRdata     (ramRdata),
        .owner        (owner)
    );

    instFetch i_instFetch (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchDone  (fetchDone),
        .fetchData  (fetchData),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .inst       (inst),
        .instPc     (instPc),
        .instValid  (instValid)
    );

    loadStore i_loadStore (
        .clk       (clk),
        .rst       (rst),
        .lsReq     (lsReq),
        .lsOp      (lsOp),
        .lsAddr    (lsAddr),
        .lsData    (lsData),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .lsBusy    (lsBusy),
        .lsDone    (lsDone),
        .lsResult  (lsResult),
        .dataReq   (dataReq),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata)
    );

    byteRam i_byteRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

// File: design/loadStore.sv
`timescale 1ns/1ps
`default_nettype none

module loadStore (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         lsReq,
    input  memPkg::memOp_t               lsOp,
    input  logic [memPkg::addrWidth-1:0] lsAddr,
    input  logic [memPkg::dataWidth-1:0] lsData,
    input  logic                         dataDone,
    input  logic [memPkg::dataWidth-1:0] dataRdata,
    output logic                         lsBusy,
    output logic                         lsDone,
    output logic [memPkg::dataWidth-1:0] lsResult,
    output logic                         dataReq,
    output logic                         dataWrite,
    output logic [2:0]                   dataLen,
    output logic [memPkg::addrWidth-1:0] dataAddr,
    output logic [memPkg::dataWidth-1:0] dataWdata
);
    import memPkg::*;

    memOp_t               opReg;
    logic                 busy;
    logic                 accept;
    logic [dataWidth-1:0] extended;

    assign accept  = lsReq && !busy;
    assign lsBusy  = busy;
    assign dataReq = busy;

    // size and direction straight from the opcode
    always_comb begin
        dataWrite = opReg inside {opSb, opSh, opSw};
        case (opReg)
            opLb, opLbu, opSb: dataLen = 3'd1;
            opLh, opLhu, opSh: dataLen = 3'd2;
            default:           dataLen = 3'd4;
        endcase
    end

    always_comb begin
        case (opReg)
            opLb:    extended = {{24{dataRdata[7]}}, dataRdata[7:0]};
            opLbu:   extended = {24'd0, dataRdata[7:0]};
            opLh:    extended = {{16{dataRdata[15]}}, dataRdata[15:0]};
            opLhu:   extended = {16'd0, dataRdata[15:0]};
            default: extended = dataRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            lsDone <= 1'b0;
        end else begin
            lsDone <= busy && dataDone;
            if (accept) begin
                busy <= 1'b1;
            end else if (dataDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opReg     <= lsOp;
            dataAddr  <= lsAddr;
            dataWdata <= lsData;
        end
        // stores leave the last load result in place
        if (busy && dataDone && !dataWrite) begin
            lsResult <= extended;
        end
    end

endmodule

`default_nettype wire

// File: design/instFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instFetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetchEn,
    input  logic                         redirect,
    input  logic [memPkg::addrWidth-1:0] redirectPc,
    input  logic                         fetchDone,
    input  logic [memPkg::dataWidth-1:0] fetchData,
    output logic                         fetchReq,
    output logic [memPkg::addrWidth-1:0] fetchAddr,
    output logic [memPkg::dataWidth-1:0] inst,
    output logic [memPkg::addrWidth-1:0] instPc,
    output logic                         instValid
);
    import memPkg::*;

    logic [addrWidth-1:0] pc;
    logic                 pending;
    logic                 discard;
    logic                 accept;

    // result of a fetch issued before a redirect is dropped
    assign accept   = fetchDone && !discard && !redirect;
    assign fetchReq = pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            pending   <= 1'b0;
            discard   <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= accept;
            if (fetchDone) begin
                pending <= 1'b0;
                discard <= 1'b0;
            end else if (!pending && fetchEn && !redirect) begin
                pending <= 1'b1;
            end
            if (accept) begin
                pc <= pc + addrWidth'(4);
            end
            if (redirect) begin
                pc <= redirectPc;
                if (pending && !fetchDone) begin
                    discard <= 1'b1;
                end
            end
        end
    end

    // address is frozen while the request is up
    always_ff @(posedge clk) begin
        if (!pending) begin
            fetchAddr <= pc;
        end
        if (accept) begin
            inst   <= fetchData;
            instPc <= fetchAddr;
        end
    end

endmodule

`default_nettype wire

// File: design/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ioBufferFull,
    input  logic                         fetchReq,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    output logic                         fetchDone,
    output logic [memPkg::dataWidth-1:0] fetchData,
    input  logic                         dataReq,
    input  logic                         dataWrite,
    input  logic [2:0]                   dataLen,
    input  logic [memPkg::addrWidth-1:0] dataAddr,
    input  logic [memPkg::dataWidth-1:0] dataWdata,
    output logic                         dataDone,
    output logic [memPkg::dataWidth-1:0] dataRdata,
    output logic                         ramWe,
    output logic [memPkg::addrWidth-1:0] ramAddr,
    output logic [7:0]                   ramWdata,
    input  logic [7:0]                   ramRdata,
    output memPkg::owner_t               owner
);
    import memPkg::*;

    ctrlState_t           state;
    logic [addrWidth-1:0] base;
    logic [2:0]           len;
    logic [2:0]           stage;
    logic [dataWidth-1:0] rdShift;
    logic [dataWidth-1:0] wrShift;
    logic [dataWidth-1:0] rdNext;
    logic [dataWidth-1:0] rdAligned;
    logic                 dataWants;
    logic                 startData;
    logic                 startFetch;
    logic                 readStep;
    logic                 readDone;
    logic                 writeDone;

    // a client is ignored during its own done cycle, its request is still up then
    assign dataWants  = dataReq && !dataDone;
    assign startData  = (state == stIdle) && !ioBufferFull && dataWants;
    assign startFetch = (state == stIdle) && !ioBufferFull && fetchReq && !fetchDone
                        && !dataWants;

    assign readStep  = (state == stRead) && !ioBufferFull;
    assign readDone  = readStep && (stage == len);
    assign writeDone = (state == stWrite) && !ioBufferFull && (stage == len - 3'd1);

    // little endian, newest byte enters at the top
    assign rdNext    = {ramRdata, rdShift[dataWidth-1:8]};
    assign rdAligned = rdNext >> {3'd4 - len, 3'b000};

    always_comb begin
        ramWe    = 1'b0;
        ramWdata = dataWdata[7:0];
        ramAddr  = startData ? dataAddr : fetchAddr;
        case (state)
            stRead: begin
                // on a stall re-read the last issued byte so rdata holds it
                ramAddr = base + addrWidth'(stage) - addrWidth'(ioBufferFull);
            end
            stWrite: begin
                ramAddr  = base + addrWidth'(stage);
                ramWe    = !ioBufferFull;
                ramWdata = wrShift[7:0];
            end
            default: begin
                ramWe = startData && dataWrite;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            owner     <= ownNone;
            len       <= 3'd0;
            stage     <= 3'd0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            case (state)
                stIdle: begin
                    // byte 0 goes out in the start cycle
                    stage <= 3'd1;
                    if (startData) begin
                        owner <= ownData;
                        len   <= dataLen;
                        if (!dataWrite) begin
                            state <= stRead;
                        end else if (dataLen == 3'd1) begin
                            dataDone <= 1'b1;
                        end else begin
                            state <= stWrite;
                        end
                    end else if (startFetch) begin
                        owner <= ownFetch;
                        len   <= 3'd4;
                        state <= stRead;
                    end else begin
                        owner <= ownNone;
                    end
                end
                stRead: begin
                    if (readDone) begin
                        state     <= stIdle;
                        fetchDone <= (owner == ownFetch);
                        dataDone  <= (owner == ownData);
                    end else if (readStep) begin
                        stage <= stage + 3'd1;
                    end
                end
                stWrite: begin
                    if (writeDone) begin
                        state    <= stIdle;
                        dataDone <= 1'b1;
                    end else if (!ioBufferFull) begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (startData || startFetch) begin
            base <= ramAddr;
        end
        if (startData) begin
            wrShift <= dataWdata >> 8;
        end else if ((state == stWrite) && !ioBufferFull) begin
            wrShift <= wrShift >> 8;
        end
        if (readStep) begin
            rdShift <= rdNext;
        end
        if (readDone && (owner == ownFetch)) begin
            fetchData <= rdAligned;
        end
        if (readDone && (owner == ownData)) begin
            dataRdata <= rdAligned;
        end
    end

endmodule

`default_nettype wire

// File: design/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic                         clk,
    input  logic                         we,
    input  logic [memPkg::addrWidth-1:0] addr,
    input  logic [7:0]                   wdata,
    output logic [7:0]                   rdata
);
    import memPkg::*;

    logic [7:0] mem [ramDepth];

    // read returns the old byte when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: design/memPkg.sv
`default_nettype none

package memPkg;

    // byte address into the shared RAM
    localparam int addrWidth = 16;

    // register and instruction width
    localparam int dataWidth = 32;

    // RAM size in bytes, covers the full address space
    localparam int ramDepth = 65536;

    // load/store opcodes
    typedef enum logic [2:0] {
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opSb,
        opSh,
        opSw
    } memOp_t;

    // who holds the RAM
    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } owner_t;

    // memCtrl sequencer states
    typedef enum logic [1:0] {
        stIdle,
        stRead,
        stWrite
    } ctrlState_t;

endpackage

`default_nettype wire
